// ==== flist.f ====
+incdir+include
hdl/wbuf_pkg.sv
hdl/beatStore.sv
hdl/burstCapture.sv
hdl/wbufDirectory.sv
hdl/phyStreamer.sv
hdl/writeBufferTop.sv
tb/writeBuffer_properties.sv
tb/tb_writeBuffer.sv

// ==== Makefile ====
# Verilator simulation of the write-data buffer

VERILATOR ?= verilator
TOP       ?= tb_writeBuffer
FLIST     ?= flist.f
BUILDDIR  ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, verdict from $(LOG)"
	@echo "  clean  remove $(BUILDDIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FLIST BUILDDIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	elif ! grep -q ">>> PASS" $(LOG); then \
		echo "Simulation ended without a verdict"; exit 1; \
	fi

clean:
	rm -rf $(BUILDDIR) $(LOG)

// ==== tb/tb_writeBuffer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "wbuf_consts.svh"

module tb_writeBuffer;

    localparam int TAG_W      = `WBUF_ID_W + `WBUF_USER_W;
    localparam int WIN_W      = `WBUF_WIN_W;
    localparam int MAX_CYCLES = 20000;                    // Generous bound on all tests
    localparam int DRAIN_WAIT = 100;                      // Cycles allowed for one burst

    logic                      clk;
    logic                      rst;
    wbuf_pkg::wbufCacheBeat_t  cacheBeat;
    logic                      cacheValid;
    logic                      ackReady;
    logic                      ackValid;
    wbuf_pkg::wbufTag_t        ackTag;
    logic                      full;
    wbuf_pkg::wbufTag_t        issueTag;
    logic                      issueValid;
    logic                      phyReady;
    logic                      phyBurstDone;
    wbuf_pkg::wbufPhyBeat_t    phyBeat;
    logic                      phyValid;
    logic [WIN_W-1:0]          window;

    // Model of the buffered bursts indexed by tag
    logic [`WBUF_DATA_W-1:0]   expData [2**TAG_W][`WBUF_BURST];
    logic [`WBUF_BURST-1:0]    expMask [2**TAG_W];

    integer seed;
    int     errCount   = 0;
    int     checkCount = 0;
    int     testCount  = 0;
    int     cycles     = 0;

    writeBufferTop i_dut (.*);

    always #2 clk = ~clk;                                 // 4 ns period

    // Run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------
    task automatic compareBeat(input string name, input wbuf_pkg::wbufPhyBeat_t exp,
                               input wbuf_pkg::wbufPhyBeat_t act);
        checkCount++;
        if (exp !== act) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            errCount++;
        end
    endtask

    task automatic compareTag(input string name, input wbuf_pkg::wbufTag_t exp,
                              input wbuf_pkg::wbufTag_t act);
        checkCount++;
        if (exp !== act) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            errCount++;
        end
    endtask

    task automatic compareCount(input string name, input logic [WIN_W-1:0] exp,
                                input logic [WIN_W-1:0] act);
        checkCount++;
        if (exp !== act) begin
            $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
            errCount++;
        end
    endtask

    task automatic compareFlag(input string name, input logic exp, input logic act);
        checkCount++;
        if (exp !== act) begin
            $display("MISMATCH %s expected %b actual %b", name, exp, act);
            errCount++;
        end
    endtask

    // ------------------------------------------------------------------------
    // Drivers
    // ------------------------------------------------------------------------
    task automatic nextCycle();
        @(posedge clk);
        #1;                                               // Drive point after the edge
    endtask

    function automatic wbuf_pkg::wbufTag_t makeTag(input int n);
        makeTag = wbuf_pkg::wbufTag_t'(TAG_W'(n));
    endfunction

    // One full burst from the front end with random data and mask
    task automatic writeBurst(input string name, input wbuf_pkg::wbufTag_t tag,
                              input logic ackRdy, input logic doneOnLast);
        logic [31:0] r;
        r = $random(seed);
        expMask[tag] = r[`WBUF_BURST-1:0];
        for (int b = 0; b < `WBUF_BURST; b++) begin
            expData[tag][b] = {$random(seed), $random(seed)};
            cacheValid      = 1'b1;
            ackReady        = ackRdy;
            cacheBeat.data  = expData[tag][b];
            cacheBeat.tag   = tag;
            cacheBeat.mask  = expMask[tag];
            cacheBeat.last  = (b == `WBUF_BURST - 1);
            phyBurstDone    = doneOnLast && cacheBeat.last;  // Optional same-cycle done
            if (cacheBeat.last) begin
                @(negedge clk);                           // Response is combinational
                compareFlag({name, " ackValid"}, ackRdy, ackValid);
                if (ackRdy) compareTag({name, " ackTag"}, tag, ackTag);
            end
            nextCycle();
        end
        cacheValid   = 1'b0;
        phyBurstDone = 1'b0;
        ackReady     = 1'b1;
    endtask

    task automatic issueWrite(input wbuf_pkg::wbufTag_t tag);
        issueTag   = tag;
        issueValid = 1'b1;                                // One-cycle strobe
        nextCycle();
        issueValid = 1'b0;
    endtask

    task automatic pulseDone();
        phyBurstDone = 1'b1;
        nextCycle();
        phyBurstDone = 1'b0;
    endtask

    // Collect one burst on the PHY side and check every beat in order
    task automatic drainBurst(input string name, input wbuf_pkg::wbufTag_t tag,
                              input logic stall);
        wbuf_pkg::wbufPhyBeat_t exp;
        int   got;
        int   waitCnt;
        logic rdy;
        logic prevReady;
        got       = 0;
        waitCnt   = 0;
        prevReady = 1'b0;
        while (got < `WBUF_BURST && waitCnt < DRAIN_WAIT) begin
            rdy      = stall ? (waitCnt % 3 != 2) : 1'b1; // Every third cycle low
            phyReady = rdy;
            @(negedge clk);
            if (!prevReady) compareFlag({name, " phyValid after stall"}, 1'b0, phyValid);
            if (phyValid) begin
                exp.data = expData[tag][got];
                exp.mask = expMask[tag][got];
                exp.last = (got == `WBUF_BURST - 1);
                compareBeat(name, exp, phyBeat);
                got++;
            end
            prevReady = rdy;
            waitCnt++;
            nextCycle();
        end
        phyReady = 1'b0;
        if (got < `WBUF_BURST) begin
            $display("%s: burst with tag %h gave only %0d beats", name, tag, got);
            errCount++;
        end
    endtask

    task automatic finishTest(input string name, input int startErr);
        string status;
        status = (errCount == startErr) ? "ok" : "with errors";
        testCount++;
        $display("test %-14s %s", name, status);
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------
    task automatic testSingle();
        int start;
        start = errCount;
        writeBurst("single", makeTag(3), 1'b1, 1'b0);
        compareCount("single window", WIN_W'(1), window);
        issueWrite(makeTag(3));
        drainBurst("single beat", makeTag(3), 1'b0);
        pulseDone();
        compareCount("single window", WIN_W'(0), window);
        finishTest("single burst", start);
    endtask

    task automatic testIssueOrder();
        int start;
        start = errCount;
        for (int i = 5; i < 8; i++) writeBurst("order", makeTag(i), 1'b1, 1'b0);
        compareCount("order window", WIN_W'(3), window);
        issueWrite(makeTag(6));                           // Second burst goes first
        drainBurst("order second", makeTag(6), 1'b0);
        pulseDone();
        issueWrite(makeTag(5));
        drainBurst("order first", makeTag(5), 1'b0);
        pulseDone();
        issueWrite(makeTag(7));
        drainBurst("order third", makeTag(7), 1'b0);
        pulseDone();
        compareCount("order window", WIN_W'(0), window);
        finishTest("issue order", start);
    endtask

    task automatic testBackPressure();
        int start;
        start = errCount;
        writeBurst("stall", makeTag(9), 1'b1, 1'b0);
        issueWrite(makeTag(9));
        drainBurst("stall beat", makeTag(9), 1'b1);
        pulseDone();
        compareCount("stall window", WIN_W'(0), window);
        finishTest("back-pressure", start);
    endtask

    task automatic testFull();
        int start;
        start = errCount;
        for (int i = 0; i < `WBUF_DEPTH; i++) writeBurst("full fill", makeTag(i), 1'b1, 1'b0);
        @(negedge clk);
        compareFlag("full set", 1'b1, full);
        compareCount("full window", WIN_W'(`WBUF_DEPTH), window);
        nextCycle();
        // Extra last beat while full carries data unlike entry 0 beat 0
        cacheValid     = 1'b1;
        cacheBeat.data = ~expData[makeTag(0)][0];
        cacheBeat.tag  = makeTag(16);
        cacheBeat.last = 1'b1;
        @(negedge clk);
        compareFlag("full extra ackValid", 1'b0, ackValid);
        nextCycle();
        cacheValid = 1'b0;
        compareCount("full extra window", WIN_W'(`WBUF_DEPTH), window);
        issueWrite(makeTag(0));
        drainBurst("full drain", makeTag(0), 1'b0);
        pulseDone();
        @(negedge clk);
        compareFlag("full cleared", 1'b0, full);
        nextCycle();
        writeBurst("full refill", makeTag(16), 1'b1, 1'b0);
        issueWrite(makeTag(16));
        drainBurst("full refill beat", makeTag(16), 1'b0);
        pulseDone();
        for (int i = 1; i < `WBUF_DEPTH; i++) begin   // Empty the rest
            issueWrite(makeTag(i));
            drainBurst("full rest", makeTag(i), 1'b0);
            pulseDone();
        end
        compareCount("full window", WIN_W'(0), window);
        finishTest("full", start);
    endtask

    task automatic testAckWindow();
        int start;
        start = errCount;
        writeBurst("ack low", makeTag(20), 1'b0, 1'b0);   // No response expected
        compareCount("ack low window", WIN_W'(1), window);
        issueWrite(makeTag(20));
        drainBurst("ack low beat", makeTag(20), 1'b0);
        writeBurst("ack done", makeTag(21), 1'b1, 1'b1);  // Last beat meets done
        compareCount("same cycle window", WIN_W'(1), window);
        issueWrite(makeTag(21));
        drainBurst("ack done beat", makeTag(21), 1'b0);
        pulseDone();
        compareCount("ack window", WIN_W'(0), window);
        finishTest("ack and window", start);
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        seed         = 32'hd55a3e8c;
        clk          = 1'b0;
        rst          = 1'b0;
        cacheBeat    = '0;
        cacheValid   = 1'b0;
        ackReady     = 1'b1;
        issueTag     = '0;
        issueValid   = 1'b0;
        phyReady     = 1'b0;
        phyBurstDone = 1'b0;
        repeat (5) @(posedge clk);
        #1 rst = 1'b1;                                    // Release after 5 cycles
        testSingle();
        testIssueOrder();
        testBackPressure();
        testFull();
        testAckWindow();
        $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errCount);
        if (errCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/writeBuffer_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module writeBuffer_properties (
    input wire logic                      clk,
    input wire logic                      rst,
    input wire wbuf_pkg::wbufCacheBeat_t  cacheBeat,
    input wire logic                      cacheValid,
    input wire logic                      ackReady,
    input wire logic                      ackValid,
    input wire logic                      full,
    input wire logic                      allocStrobe,  // Internal to the top level
    input wire wbuf_pkg::wbufPhyBeat_t    phyBeat,
    input wire logic                      phyValid
);

    // Last flag only rides on a valid PHY beat
    lastWithValid: assert property (@(posedge clk) disable iff (!rst)
        phyBeat.last |-> phyValid)
        else $error("phyBeat.last high without phyValid");

    // Response only for an accepted last beat
    ackOnAcceptedLast: assert property (@(posedge clk) disable iff (!rst)
        ackValid |-> (cacheValid && !full && cacheBeat.last && ackReady))
        else $error("ackValid without an accepted last beat");

    // No allocation into a full directory
    noAllocWhenFull: assert property (@(posedge clk) disable iff (!rst)
        !(full && allocStrobe))
        else $error("allocStrobe while full");

endmodule

bind writeBufferTop writeBuffer_properties uProps (
    .clk(clk),
    .rst(rst),
    .cacheBeat(cacheBeat),
    .cacheValid(cacheValid),
    .ackReady(ackReady),
    .ackValid(ackValid),
    .full(full),
    .allocStrobe(allocStrobe),
    .phyBeat(phyBeat),
    .phyValid(phyValid)
);

`default_nettype wire

// ==== hdl/writeBufferTop.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "wbuf_consts.svh"

module writeBufferTop (
    input  wire logic                       clk,
    input  wire logic                       rst,
    // Front end
    input  wire wbuf_pkg::wbufCacheBeat_t   cacheBeat,
    input  wire logic                       cacheValid,
    input  wire logic                       ackReady,
    output      logic                       ackValid,
    output      wbuf_pkg::wbufTag_t         ackTag,
    output      logic                       full,
    // Command side
    input  wire wbuf_pkg::wbufTag_t         issueTag,
    input  wire logic                       issueValid,
    // PHY side
    input  wire logic                       phyReady,
    input  wire logic                       phyBurstDone,
    output      wbuf_pkg::wbufPhyBeat_t     phyBeat,
    output      logic                       phyValid,
    // Outstanding writes
    output      logic [`WBUF_WIN_W-1:0]     window
);

    // -------------------------------------------------------------------------
    // Internal wires
    // -------------------------------------------------------------------------
    logic                      allocStrobe;               // Burst complete, take an entry
    wbuf_pkg::wbufTag_t        allocTag;
    logic [`WBUF_BURST-1:0]    allocMask;
    wbuf_pkg::wbufIdx_t        allocIdx;                  // Entry being filled

    logic                      storeWe;
    wbuf_pkg::wbufAddr_t       storeWaddr;
    logic [`WBUF_DATA_W-1:0]   storeData;
    logic                      storeRe;
    wbuf_pkg::wbufAddr_t       storeRaddr;
    logic [`WBUF_DATA_W-1:0]   storeRdata;

    logic                      serveAvail;                // An issued burst is ready
    wbuf_pkg::wbufIdx_t        serveIdx;
    logic [`WBUF_BURST-1:0]    serveMask;
    logic                      burstStart;
    logic                      burstEnd;

    // -------------------------------------------------------------------------
    // Blocks
    // -------------------------------------------------------------------------
    burstCapture uCapture (
        .clk(clk), .rst(rst),
        .cacheBeat(cacheBeat), .cacheValid(cacheValid), .full(full),
        .ackReady(ackReady), .allocIdx(allocIdx), .phyBurstDone(phyBurstDone),
        .ackValid(ackValid), .ackTag(ackTag),
        .allocStrobe(allocStrobe), .allocTag(allocTag), .allocMask(allocMask),
        .storeWe(storeWe), .storeWaddr(storeWaddr), .storeData(storeData),
        .window(window)
    );

    wbufDirectory uDirectory (
        .clk(clk), .rst(rst),
        .allocStrobe(allocStrobe), .allocTag(allocTag), .allocMask(allocMask),
        .issueValid(issueValid), .issueTag(issueTag),
        .burstStart(burstStart), .burstEnd(burstEnd),
        .allocIdx(allocIdx), .full(full),
        .serveAvail(serveAvail), .serveIdx(serveIdx), .serveMask(serveMask)
    );

    beatStore uStore (
        .clk(clk),
        .we(storeWe), .waddr(storeWaddr), .wdata(storeData),
        .re(storeRe), .raddr(storeRaddr), .rdata(storeRdata)
    );

    phyStreamer uStreamer (
        .clk(clk), .rst(rst),
        .serveAvail(serveAvail), .serveIdx(serveIdx), .serveMask(serveMask),
        .phyReady(phyReady), .rdata(storeRdata),
        .storeRe(storeRe), .storeRaddr(storeRaddr),
        .burstStart(burstStart), .burstEnd(burstEnd),
        .phyBeat(phyBeat), .phyValid(phyValid)
    );

endmodule

`default_nettype wire

// ==== hdl/phyStreamer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "wbuf_consts.svh"

module phyStreamer (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     serveAvail,
    input  wire wbuf_pkg::wbufIdx_t       serveIdx,
    input  wire logic [`WBUF_BURST-1:0]   serveMask,
    input  wire logic                     phyReady,
    input  wire logic [`WBUF_DATA_W-1:0]  rdata,
    output      logic                     storeRe,
    output      wbuf_pkg::wbufAddr_t      storeRaddr,
    output      logic                     burstStart,
    output      logic                     burstEnd,
    output      wbuf_pkg::wbufPhyBeat_t   phyBeat,
    output      logic                     phyValid
);

    localparam wbuf_pkg::wbufBeat_t lastBeat = wbuf_pkg::wbufBeat_t'(`WBUF_BURST - 1);

    logic                 rdGo;                           // One beat read this cycle
    wbuf_pkg::wbufBeat_t  rdCnt;                          // Next beat of the served burst
    logic                 maskQ;
    logic                 lastQ;

    // -------------------------------------------------------------------------
    // Serve decision and read address
    // -------------------------------------------------------------------------
    assign rdGo       = serveAvail && phyReady;           // PHY low keeps the position
    assign storeRe    = rdGo;
    assign storeRaddr = {serveIdx, rdCnt};

    assign burstStart = rdGo && (rdCnt == '0);
    assign burstEnd   = rdGo && (rdCnt == lastBeat);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rdCnt <= '0;
        end else if (rdGo) begin
            if (rdCnt == lastBeat) rdCnt <= '0;           // Ready for the next burst
            else                   rdCnt <= rdCnt + 1'b1;
        end
    end

    // -------------------------------------------------------------------------
    // Output stage, aligned with the store read data
    // -------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            phyValid <= 1'b0;
            maskQ    <= 1'b0;
            lastQ    <= 1'b0;
        end else begin
            phyValid <= rdGo;
            maskQ    <= rdGo && serveMask[rdCnt];         // Mask bit of this beat position
            lastQ    <= burstEnd;
        end
    end

    // Data is already registered inside the store
    assign phyBeat.data = rdata;
    assign phyBeat.mask = maskQ;
    assign phyBeat.last = lastQ;

endmodule

`default_nettype wire

// ==== hdl/wbufDirectory.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "wbuf_consts.svh"

module wbufDirectory (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    allocStrobe,
    input  wire wbuf_pkg::wbufTag_t      allocTag,
    input  wire logic [`WBUF_BURST-1:0]  allocMask,
    input  wire logic                    issueValid,
    input  wire wbuf_pkg::wbufTag_t      issueTag,
    input  wire logic                    burstStart,
    input  wire logic                    burstEnd,
    output      wbuf_pkg::wbufIdx_t      allocIdx,
    output      logic                    full,
    output      logic                    serveAvail,
    output      wbuf_pkg::wbufIdx_t      serveIdx,
    output      logic [`WBUF_BURST-1:0]  serveMask
);

    // -------------------------------------------------------------------------
    // Entry table
    // -------------------------------------------------------------------------
    logic [`WBUF_DEPTH-1:0]  valid;                       // Entry holds a complete burst
    logic [`WBUF_DEPTH-1:0]  issued;                      // Command side has sent the write
    wbuf_pkg::wbufTag_t      tagMem  [`WBUF_DEPTH];
    logic [`WBUF_BURST-1:0]  maskMem [`WBUF_DEPTH];

    logic [`WBUF_DEPTH-1:0]  validNext;
    logic [`WBUF_DEPTH-1:0]  issuedNext;
    wbuf_pkg::wbufIdx_t      freeIdx;                     // Lowest free entry after this edge
    logic                    issueHit;
    wbuf_pkg::wbufIdx_t      issueIdx;
    logic                    pickHit;
    wbuf_pkg::wbufIdx_t      pickIdx;                     // Lowest issued entry
    logic                    busy;                        // Burst in flight to the PHY
    wbuf_pkg::wbufIdx_t      curIdx;

    // Issue match and serve pick where the lowest index wins
    always_comb begin
        issueHit = 1'b0;
        issueIdx = '0;
        pickHit  = 1'b0;
        pickIdx  = '0;
        for (int i = `WBUF_DEPTH - 1; i >= 0; i--) begin
            if (valid[i] && !issued[i] && tagMem[i] == issueTag) begin
                issueHit = 1'b1;
                issueIdx = wbuf_pkg::wbufIdx_t'(i);
            end
            if (issued[i]) begin
                pickHit = 1'b1;
                pickIdx = wbuf_pkg::wbufIdx_t'(i);
            end
        end
    end

    // Lowest free entry once this cycle's updates are in
    always_comb begin
        freeIdx = '0;
        for (int i = `WBUF_DEPTH - 1; i >= 0; i--) begin
            if (!validNext[i]) freeIdx = wbuf_pkg::wbufIdx_t'(i);
        end
    end

    // Next state of the valid and issued vectors
    always_comb begin
        validNext  = valid;
        issuedNext = issued;
        if (issueValid && issueHit) issuedNext[issueIdx] = 1'b1;
        if (allocStrobe) begin
            validNext[allocIdx]  = 1'b1;
            issuedNext[allocIdx] = 1'b0;
        end
        if (burstEnd) begin                               // Release after the final read
            validNext[serveIdx]  = 1'b0;
            issuedNext[serveIdx] = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid    <= '0;
            issued   <= '0;
            allocIdx <= '0;
            busy     <= 1'b0;
            curIdx   <= '0;
        end else begin
            valid  <= validNext;
            issued <= issuedNext;
            // Fill pointer moves only once its entry is taken,
            // so all beats of a burst land in one entry
            if (validNext[allocIdx]) allocIdx <= freeIdx;
            if (burstEnd) begin
                busy <= 1'b0;
            end else if (burstStart) begin
                busy   <= 1'b1;                           // Lock the choice for this burst
                curIdx <= serveIdx;
            end
        end
    end

    // Tag and mask written on allocation
    always_ff @(posedge clk) begin
        if (allocStrobe) begin
            tagMem[allocIdx]  <= allocTag;
            maskMem[allocIdx] <= allocMask;
        end
    end

    // -------------------------------------------------------------------------
    // Outputs
    // -------------------------------------------------------------------------
    assign full       = &valid;                           // No free entry
    assign serveIdx   = busy ? curIdx : pickIdx;
    assign serveAvail = busy | pickHit;
    assign serveMask  = maskMem[serveIdx];

endmodule

`default_nettype wire

// ==== hdl/burstCapture.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "wbuf_consts.svh"

module burstCapture (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire wbuf_pkg::wbufCacheBeat_t   cacheBeat,
    input  wire logic                       cacheValid,
    input  wire logic                       full,
    input  wire logic                       ackReady,
    input  wire wbuf_pkg::wbufIdx_t         allocIdx,
    input  wire logic                       phyBurstDone,
    output      logic                       ackValid,
    output      wbuf_pkg::wbufTag_t         ackTag,
    output      logic                       allocStrobe,
    output      wbuf_pkg::wbufTag_t         allocTag,
    output      logic [`WBUF_BURST-1:0]     allocMask,
    output      logic                       storeWe,
    output      wbuf_pkg::wbufAddr_t        storeWaddr,
    output      logic [`WBUF_DATA_W-1:0]    storeData,
    output      logic [`WBUF_WIN_W-1:0]     window
);

    logic                 accept;                         // Beat taken this cycle
    wbuf_pkg::wbufBeat_t  beatCnt;                        // Position inside the current burst

    assign accept = cacheValid && !full;

    // -------------------------------------------------------------------------
    // Beat capture
    // -------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            beatCnt <= '0;
        end else if (accept) begin
            if (cacheBeat.last) beatCnt <= '0;            // Next burst starts at beat 0
            else                beatCnt <= beatCnt + 1'b1;
        end
    end

    assign storeWe    = accept;
    assign storeWaddr = {allocIdx, beatCnt};              // Entry base plus beat offset
    assign storeData  = cacheBeat.data;

    // Directory allocation on the final beat
    assign allocStrobe = accept && cacheBeat.last;
    assign allocTag    = cacheBeat.tag;
    assign allocMask   = cacheBeat.mask;

    // Write response
    assign ackValid = allocStrobe && ackReady;
    assign ackTag   = cacheBeat.tag;

    // -------------------------------------------------------------------------
    // Outstanding write window
    // -------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            window <= '0;
        end else begin
            case ({allocStrobe, phyBurstDone})
                2'b10:   window <= window + 1'b1;         // New burst buffered
                2'b01:   window <= window - 1'b1;         // PHY finished one
                default: window <= window;                // Both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/beatStore.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "wbuf_consts.svh"

module beatStore (
    input  wire logic                     clk,
    input  wire logic                     we,
    input  wire wbuf_pkg::wbufAddr_t      waddr,
    input  wire logic [`WBUF_DATA_W-1:0]  wdata,
    input  wire logic                     re,
    input  wire wbuf_pkg::wbufAddr_t      raddr,
    output      logic [`WBUF_DATA_W-1:0]  rdata
);

    // One slot per beat of every entry
    logic [`WBUF_DATA_W-1:0] mem [`WBUF_DEPTH * `WBUF_BURST];

    // Write port, front end side
    always_ff @(posedge clk) begin
        if (we) mem[waddr] <= wdata;
    end

    // Read port, PHY side, one cycle latency
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr];                          // Holds last beat when idle
        end
    end

endmodule

`default_nettype wire

// ==== hdl/wbuf_pkg.sv ====
`default_nettype none

`include "wbuf_consts.svh"

package wbuf_pkg;

    // ID and user of one write, matched against the command side
    typedef struct packed {
        logic [`WBUF_ID_W-1:0]   id;
        logic [`WBUF_USER_W-1:0] user;
    } wbufTag_t;

    // One beat from the front end
    typedef struct packed {
        logic [`WBUF_DATA_W-1:0] data;
        wbufTag_t                tag;                     // Same on every beat of a burst
        logic [`WBUF_BURST-1:0]  mask;                    // One bit per beat
        logic                    last;                    // Marks beat WBUF_BURST-1
    } wbufCacheBeat_t;

    // One beat to the PHY
    typedef struct packed {
        logic [`WBUF_DATA_W-1:0] data;
        logic                    mask;                    // Mask bit of this beat
        logic                    last;
    } wbufPhyBeat_t;

    // Index types
    typedef logic [`WBUF_IDX_W-1:0]  wbufIdx_t;           // Directory entry
    typedef logic [`WBUF_BEAT_W-1:0] wbufBeat_t;          // Beat within a burst
    typedef logic [`WBUF_ADDR_W-1:0] wbufAddr_t;          // {entry, beat}

endpackage

`default_nettype wire

// ==== include/wbuf_consts.svh ====
`ifndef WBUF_CONSTS_SVH
`define WBUF_CONSTS_SVH

// ---------------------------------------------------------------------------
// Buffer geometry
// ---------------------------------------------------------------------------
`define WBUF_DEPTH   16                                   // Directory entries
`define WBUF_BURST   8                                    // Beats per burst

// Field widths
`define WBUF_DATA_W  64                                   // One beat of write data
`define WBUF_ID_W    4
`define WBUF_USER_W  1

// Derived widths
`define WBUF_IDX_W   ($clog2(`WBUF_DEPTH))                // Entry index
`define WBUF_BEAT_W  ($clog2(`WBUF_BURST))                // Beat position in a burst
`define WBUF_ADDR_W  (`WBUF_IDX_W + `WBUF_BEAT_W)         // Beat store address
`define WBUF_WIN_W   ($clog2(`WBUF_DEPTH + 1))            // Holds 0 up to WBUF_DEPTH

`endif
